// File: logic/lbc_cmd_pkg.sv
package lbc_cmd_pkg;

  // cpu transfer size, matches the low bits of the bus opcode
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lbc_size_e;

  // bit 3 marks a write, bits 1:0 carry the size
  typedef enum logic [3:0] {
    CMD_RD_BYTE = 4'h0,
    CMD_RD_HALF = 4'h1,
    CMD_RD_WORD = 4'h2,
    CMD_WR_BYTE = 4'h8,
    CMD_WR_HALF = 4'h9,
    CMD_WR_WORD = 4'ha
  } lbc_cmd_e;

  function automatic lbc_cmd_e lbc_make_cmd(logic rw, lbc_size_e size);
    return lbc_cmd_e'({rw, 1'b0, size});
  endfunction

  function automatic logic lbc_cmd_is_write(lbc_cmd_e cmd);
    return cmd[3];
  endfunction

  function automatic lbc_size_e lbc_cmd_size(lbc_cmd_e cmd);
    return lbc_size_e'(cmd[1:0]);
  endfunction

endpackage

// File: logic/lbc_bus_pkg.sv
package lbc_bus_pkg;

  // address and data share one width on the local bus
  localparam int LBC_DATA_W = 32;

  localparam int LBC_BE_W = LBC_DATA_W / 8;

  // address bits that pick a byte lane
  localparam int LBC_LANE_W = $clog2(LBC_BE_W);

  // shortest synchronizer chain that still settles metastability
  localparam int LBC_SYNC_MIN = 2;

endpackage

// File: logic/lbc_async.sv
module lbc_async #(
  parameter int SYNC_STAGES = 2
) (
  input  logic sysclk,
  input  logic busclk,
  input  logic arst_n,
  input  logic xfer_req,
  output logic bus_req,
  input  logic bus_ack,
  output logic xfer_ack
);
  import lbc_bus_pkg::*;

  localparam int STAGES = (SYNC_STAGES < LBC_SYNC_MIN) ? LBC_SYNC_MIN : SYNC_STAGES;

  logic [STAGES-1:0] req_sync;
  logic [STAGES-1:0] ack_sync;

  // request travels into the bus domain
  always_ff @(posedge busclk or negedge arst_n) begin
    if (!arst_n) begin
      req_sync <= '0;
    end else begin
      req_sync <= {req_sync[STAGES-2:0], xfer_req};
    end
  end

  // acknowledge comes back into the cpu domain
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[STAGES-2:0], bus_ack};
    end
  end

  assign bus_req  = req_sync[STAGES-1];
  assign xfer_ack = ack_sync[STAGES-1];

  // source may only withdraw the request once the ack has arrived
  a_req_held: assert property (@(posedge sysclk) disable iff (!arst_n)
    $fell(xfer_req) |-> $past(xfer_ack))
    else $error("xfer_req dropped before xfer_ack");

  // destination keeps the ack up until the request is gone
  a_ack_held: assert property (@(posedge busclk) disable iff (!arst_n)
    $fell(bus_ack) |-> !$past(bus_req))
    else $error("bus_ack dropped while bus_req still high");

endmodule

// File: logic/lbc_cbus_decode.sv
module lbc_cbus_decode (
  input  logic                               sysclk,
  input  logic                               arst_n,
  input  logic                               cpu_req,
  input  logic                               cpu_rw,
  input  lbc_cmd_pkg::lbc_size_e             cpu_size,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] cpu_addr,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] cpu_wdata,
  input  logic                               xfer_ack,
  output logic                               cpu_halt,
  output logic                               cpu_wbempty,
  output logic                               cpu_align_err,
  output logic                               xfer_req,
  output lbc_cmd_pkg::lbc_cmd_e              xfer_cmd,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] xfer_addr,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] xfer_wdata,
  output logic [lbc_bus_pkg::LBC_BE_W-1:0]   xfer_be
);
  import lbc_cmd_pkg::*;
  import lbc_bus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE
  } state_e;

  state_e                state;
  logic                  rd_halt;
  logic                  aligned;
  logic                  accept;
  logic                  busy;
  logic [LBC_LANE_W-1:0] lane;
  logic [LBC_BE_W-1:0]   be_base;

  assign lane = cpu_addr[LBC_LANE_W-1:0];

  always_comb begin
    aligned = 1'b0;
    be_base = '0;
    case (cpu_size)
      SIZE_BYTE: begin
        aligned = 1'b1;
        be_base = LBC_BE_W'(4'b0001);
      end
      SIZE_HALF: begin
        aligned = ~lane[0];
        be_base = LBC_BE_W'(4'b0011);
      end
      SIZE_WORD: begin
        aligned = (lane == '0);
        be_base = '1;
      end
      default: begin
        aligned = 1'b0;
      end
    endcase
  end

  // buffer is busy until the whole handshake is back at rest
  assign busy        = (state != IDLE);
  assign cpu_wbempty = ~busy;

  // a pending read holds the cpu, a new aligned request waits for the buffer
  assign cpu_halt = rd_halt | (cpu_req & aligned & busy);
  assign accept   = cpu_req & ~cpu_halt;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= IDLE;
      xfer_req      <= 1'b0;
      rd_halt       <= 1'b0;
      cpu_align_err <= 1'b0;
    end else begin
      cpu_align_err <= accept & ~aligned;
      case (state)
        IDLE: begin
          if (accept && aligned) begin
            xfer_req <= 1'b1;
            rd_halt  <= ~cpu_rw;
            state    <= REQ;
          end
        end
        REQ: begin
          // halt falls together with the result pulse
          if (xfer_ack) begin
            xfer_req <= 1'b0;
            rd_halt  <= 1'b0;
            state    <= RELEASE;
          end
        end
        RELEASE: begin
          if (!xfer_ack) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge sysclk) begin
    if (accept && aligned) begin
      xfer_cmd   <= lbc_make_cmd(cpu_rw, cpu_size);
      xfer_addr  <= cpu_addr;
      xfer_be    <= be_base << lane;
      xfer_wdata <= cpu_wdata << {lane, 3'b000};
    end
  end

  a_fields_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
    xfer_req && $past(xfer_req) |-> $stable({xfer_cmd, xfer_addr, xfer_wdata, xfer_be}))
    else $error("command fields changed while xfer_req high");

endmodule

// File: logic/lbc_lbus_exec.sv
module lbc_lbus_exec #(
  parameter int MAX_WAIT = 16
) (
  input  logic                               busclk,
  input  logic                               arst_n,
  input  logic                               bus_req,
  input  lbc_cmd_pkg::lbc_cmd_e              xfer_cmd,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] xfer_addr,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] xfer_wdata,
  input  logic [lbc_bus_pkg::LBC_BE_W-1:0]   xfer_be,
  input  logic                               lbus_gnt,
  input  logic                               lbus_trdy,
  input  logic                               lbus_abort,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] lbus_data,
  output logic                               bus_ack,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] bus_rdata,
  output logic                               bus_timeout,
  output logic                               lbc_req,
  output logic                               lbc_frame,
  output logic                               lbc_irdy,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] lbc_addr,
  output lbc_cmd_pkg::lbc_cmd_e              lbc_cmd,
  output logic [lbc_bus_pkg::LBC_BE_W-1:0]   lbc_be,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] lbc_data,
  output logic                               lbc_data_oe
);
  import lbc_cmd_pkg::*;

  localparam int CNT_W = $clog2(MAX_WAIT + 1);

  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    ADDRESS,
    DATA,
    ACK
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] wait_cnt;
  logic             is_write;
  logic             timed_out;

  assign is_write  = lbc_cmd_is_write(xfer_cmd);
  assign timed_out = (wait_cnt == CNT_W'(MAX_WAIT - 1));

  always_ff @(posedge busclk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      wait_cnt    <= '0;
      bus_ack     <= 1'b0;
      bus_timeout <= 1'b0;
      lbc_req     <= 1'b0;
      lbc_frame   <= 1'b0;
      lbc_irdy    <= 1'b0;
      lbc_data_oe <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (bus_req) begin
            lbc_req <= 1'b1;
            state   <= REQUEST;
          end
        end
        REQUEST: begin
          if (lbus_gnt) begin
            lbc_frame <= 1'b1;
            state     <= ADDRESS;
          end
        end
        ADDRESS: begin
          lbc_irdy    <= 1'b1;
          lbc_data_oe <= is_write;
          wait_cnt    <= '0;
          state       <= DATA;
        end
        DATA: begin
          if (lbus_trdy || lbus_abort || timed_out) begin
            lbc_frame   <= 1'b0;
            lbc_irdy    <= 1'b0;
            lbc_data_oe <= 1'b0;
          end
          if (lbus_trdy) begin
            lbc_req     <= 1'b0;
            bus_ack     <= 1'b1;
            bus_timeout <= 1'b0;
            state       <= ACK;
          end else if (lbus_abort) begin
            // keep requesting and run the whole transfer again
            state <= REQUEST;
          end else if (timed_out) begin
            lbc_req     <= 1'b0;
            bus_ack     <= 1'b1;
            bus_timeout <= 1'b1;
            state       <= ACK;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ACK: begin
          if (!bus_req) begin
            bus_ack <= 1'b0;
            state   <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge busclk) begin
    if (state == REQUEST && lbus_gnt) begin
      lbc_addr <= xfer_addr;
      lbc_cmd  <= xfer_cmd;
      lbc_be   <= xfer_be;
      lbc_data <= xfer_wdata;
    end
    if (state == DATA && lbus_trdy && !is_write) begin
      bus_rdata <= lbus_data;
    end
  end

  // data phase sits inside frame and always follows an address phase
  a_irdy_framed: assert property (@(posedge busclk) disable iff (!arst_n)
    lbc_irdy |-> lbc_frame && $past(lbc_frame))
    else $error("lbc_irdy outside a framed transfer");

endmodule

// File: logic/lbc_result.sv
module lbc_result (
  input  logic                               sysclk,
  input  logic                               arst_n,
  input  logic                               xfer_ack,
  input  lbc_cmd_pkg::lbc_cmd_e              xfer_cmd,
  input  logic [lbc_bus_pkg::LBC_LANE_W-1:0] xfer_addr,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] bus_rdata,
  input  logic                               bus_timeout,
  output logic                               cpu_rval,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] cpu_rdata,
  output logic                               cpu_bus_err
);
  import lbc_cmd_pkg::*;
  import lbc_bus_pkg::*;

  logic                  ack_q;
  logic                  ack_rise;
  logic                  is_read;
  logic [LBC_DATA_W-1:0] lane_data;
  logic [LBC_DATA_W-1:0] size_mask;

  assign ack_rise = xfer_ack & ~ack_q;
  assign is_read  = ~lbc_cmd_is_write(xfer_cmd);

  // move the addressed lane down to bit 0
  assign lane_data = bus_rdata >> {xfer_addr, 3'b000};

  always_comb begin
    case (lbc_cmd_size(xfer_cmd))
      SIZE_BYTE: size_mask = LBC_DATA_W'(8'hff);
      SIZE_HALF: size_mask = LBC_DATA_W'(16'hffff);
      default:   size_mask = '1;
    endcase
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q       <= 1'b0;
      cpu_rval    <= 1'b0;
      cpu_bus_err <= 1'b0;
    end else begin
      ack_q       <= xfer_ack;
      cpu_rval    <= ack_rise & ~bus_timeout & is_read;
      cpu_bus_err <= ack_rise & bus_timeout;
    end
  end

  // rdata and timeout are frozen while the ack is up
  always_ff @(posedge sysclk) begin
    if (ack_rise && is_read) begin
      cpu_rdata <= lane_data & size_mask;
    end
  end

endmodule

// File: logic/lbc_lbi.sv
module lbc_lbi #(
  parameter int SYNC_STAGES = 2,
  parameter int MAX_WAIT    = 16
) (
  input  logic                               sysclk,
  input  logic                               busclk,
  input  logic                               arst_n,
  input  logic                               cpu_req,
  input  logic                               cpu_rw,
  input  lbc_cmd_pkg::lbc_size_e             cpu_size,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] cpu_addr,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] cpu_wdata,
  output logic                               cpu_halt,
  output logic                               cpu_rval,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] cpu_rdata,
  output logic                               cpu_align_err,
  output logic                               cpu_bus_err,
  output logic                               cpu_wbempty,
  input  logic                               lbus_gnt,
  input  logic                               lbus_trdy,
  input  logic                               lbus_abort,
  input  logic [lbc_bus_pkg::LBC_DATA_W-1:0] lbus_data,
  output logic                               lbc_req,
  output logic                               lbc_frame,
  output logic                               lbc_irdy,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] lbc_addr,
  output lbc_cmd_pkg::lbc_cmd_e              lbc_cmd,
  output logic [lbc_bus_pkg::LBC_BE_W-1:0]   lbc_be,
  output logic [lbc_bus_pkg::LBC_DATA_W-1:0] lbc_data,
  output logic                               lbc_data_oe
);
  import lbc_cmd_pkg::*;
  import lbc_bus_pkg::*;

  // sysclk side of the crossing
  logic                  xfer_req;
  logic                  xfer_ack;
  lbc_cmd_e              xfer_cmd;
  logic [LBC_DATA_W-1:0] xfer_addr;
  logic [LBC_DATA_W-1:0] xfer_wdata;
  logic [LBC_BE_W-1:0]   xfer_be;

  // busclk side of the crossing
  logic                  bus_req;
  logic                  bus_ack;
  logic [LBC_DATA_W-1:0] bus_rdata;
  logic                  bus_timeout;

  lbc_cbus_decode i_decode (
    .sysclk        (sysclk),
    .arst_n        (arst_n),
    .cpu_req       (cpu_req),
    .cpu_rw        (cpu_rw),
    .cpu_size      (cpu_size),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .xfer_ack      (xfer_ack),
    .cpu_halt      (cpu_halt),
    .cpu_wbempty   (cpu_wbempty),
    .cpu_align_err (cpu_align_err),
    .xfer_req      (xfer_req),
    .xfer_cmd      (xfer_cmd),
    .xfer_addr     (xfer_addr),
    .xfer_wdata    (xfer_wdata),
    .xfer_be       (xfer_be)
  );

  lbc_async #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_async (
    .sysclk   (sysclk),
    .busclk   (busclk),
    .arst_n   (arst_n),
    .xfer_req (xfer_req),
    .bus_req  (bus_req),
    .bus_ack  (bus_ack),
    .xfer_ack (xfer_ack)
  );

  lbc_lbus_exec #(
    .MAX_WAIT (MAX_WAIT)
  ) i_exec (
    .busclk      (busclk),
    .arst_n      (arst_n),
    .bus_req     (bus_req),
    .xfer_cmd    (xfer_cmd),
    .xfer_addr   (xfer_addr),
    .xfer_wdata  (xfer_wdata),
    .xfer_be     (xfer_be),
    .lbus_gnt    (lbus_gnt),
    .lbus_trdy   (lbus_trdy),
    .lbus_abort  (lbus_abort),
    .lbus_data   (lbus_data),
    .bus_ack     (bus_ack),
    .bus_rdata   (bus_rdata),
    .bus_timeout (bus_timeout),
    .lbc_req     (lbc_req),
    .lbc_frame   (lbc_frame),
    .lbc_irdy    (lbc_irdy),
    .lbc_addr    (lbc_addr),
    .lbc_cmd     (lbc_cmd),
    .lbc_be      (lbc_be),
    .lbc_data    (lbc_data),
    .lbc_data_oe (lbc_data_oe)
  );

  lbc_result i_result (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .xfer_ack    (xfer_ack),
    .xfer_cmd    (xfer_cmd),
    .xfer_addr   (xfer_addr[LBC_LANE_W-1:0]),
    .bus_rdata   (bus_rdata),
    .bus_timeout (bus_timeout),
    .cpu_rval    (cpu_rval),
    .cpu_rdata   (cpu_rdata),
    .cpu_bus_err (cpu_bus_err)
  );

endmodule

// File: bench/lbc_bus_target.sv
module lbc_bus_target (
  input  logic        busclk,
  input  logic        arst_n,
  input  logic        lbc_req,
  input  logic        lbc_frame,
  input  logic        lbc_irdy,
  input  logic [31:0] lbc_addr,
  input  logic [3:0]  lbc_be,
  input  logic [31:0] lbc_data,
  input  logic        lbc_data_oe,
  input  logic [7:0]  wait_n,
  input  logic        abort_once,
  input  logic        stall,
  output logic        lbus_gnt,
  output logic        lbus_trdy,
  output logic        lbus_abort,
  output logic [31:0] lbus_data,
  output logic [3:0]  last_be
);

  logic [31:0] mem [64];
  logic [7:0]  wcnt;
  logic        abort_used;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000;
    end
  end

  // responses change on the falling edge, the master samples on the rising one
  always @(negedge busclk or negedge arst_n) begin
    if (!arst_n) begin
      lbus_gnt   <= 1'b0;
      lbus_trdy  <= 1'b0;
      lbus_abort <= 1'b0;
      lbus_data  <= '0;
      wcnt       <= '0;
      abort_used <= 1'b0;
    end else begin
      lbus_gnt   <= lbc_req;
      lbus_trdy  <= 1'b0;
      lbus_abort <= 1'b0;
      if (lbc_irdy && !lbus_trdy && !lbus_abort) begin
        if (abort_once && !abort_used) begin
          lbus_abort <= 1'b1;
          abort_used <= 1'b1;
          wcnt       <= '0;
        end else if (!stall && wcnt >= wait_n) begin
          lbus_trdy <= 1'b1;
          lbus_data <= mem[lbc_addr[7:2]];
          wcnt      <= '0;
        end else begin
          wcnt <= wcnt + 1'b1;
        end
      end else if (!lbc_irdy) begin
        wcnt <= '0;
      end
      if (!abort_once) begin
        abort_used <= 1'b0;
      end
    end
  end

  always @(posedge busclk) begin
    // address phase is the framed cycle before irdy
    if (lbc_frame && !lbc_irdy) begin
      last_be <= lbc_be;
    end
    if (lbc_irdy && lbus_trdy && lbc_data_oe) begin
      for (int k = 0; k < 4; k++) begin
        if (lbc_be[k]) begin
          mem[lbc_addr[7:2]][8*k +: 8] <= lbc_data[8*k +: 8];
        end
      end
    end
  end

endmodule

// File: bench/lbc_lbi_tb.sv
module lbc_lbi_tb;
  import lbc_cmd_pkg::*;

  localparam int SYNC_STAGES = 2;
  localparam int MAX_WAIT    = 16;
  localparam int XFER_COUNT  = 35;
  localparam int LIMIT       = 400;

  logic        sysclk = 1'b0;
  logic        busclk = 1'b0;
  logic        arst_n;
  logic        cpu_req;
  logic        cpu_rw;
  lbc_size_e   cpu_size;
  logic [31:0] cpu_addr;
  logic [31:0] cpu_wdata;
  logic        cpu_halt;
  logic        cpu_rval;
  logic [31:0] cpu_rdata;
  logic        cpu_align_err;
  logic        cpu_bus_err;
  logic        cpu_wbempty;
  logic        lbus_gnt;
  logic        lbus_trdy;
  logic        lbus_abort;
  logic [31:0] lbus_data;
  logic        lbc_req;
  logic        lbc_frame;
  logic        lbc_irdy;
  logic [31:0] lbc_addr;
  lbc_cmd_e    lbc_cmd;
  logic [3:0]  lbc_be;
  logic [31:0] lbc_data;
  logic        lbc_data_oe;
  logic [7:0]  wait_n;
  logic        abort_once;
  logic        stall;
  logic [3:0]  last_be;
  lbc_cmd_e    last_cmd;

  logic [31:0] ref_mem [64];
  logic [31:0] rng_state = 32'd9122;
  int          err_cnt   = 0;
  int          tests_ok  = 0;
  int          tests_bad = 0;
  int          req_count = 0;

  always #50 sysclk = ~sysclk;
  always #65 busclk = ~busclk;

  always @(posedge lbc_req) req_count++;

  // opcode of the address phase, the framed cycle before irdy
  always @(posedge busclk) begin
    if (lbc_frame && !lbc_irdy) begin
      last_cmd <= lbc_cmd;
    end
  end

  lbc_lbi #(
    .SYNC_STAGES (SYNC_STAGES),
    .MAX_WAIT    (MAX_WAIT)
  ) i_lbc_lbi (
    .sysclk (sysclk), .busclk (busclk), .arst_n (arst_n),
    .cpu_req (cpu_req), .cpu_rw (cpu_rw), .cpu_size (cpu_size),
    .cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata),
    .cpu_halt (cpu_halt), .cpu_rval (cpu_rval), .cpu_rdata (cpu_rdata),
    .cpu_align_err (cpu_align_err), .cpu_bus_err (cpu_bus_err),
    .cpu_wbempty (cpu_wbempty),
    .lbus_gnt (lbus_gnt), .lbus_trdy (lbus_trdy), .lbus_abort (lbus_abort),
    .lbus_data (lbus_data),
    .lbc_req (lbc_req), .lbc_frame (lbc_frame), .lbc_irdy (lbc_irdy),
    .lbc_addr (lbc_addr), .lbc_cmd (lbc_cmd), .lbc_be (lbc_be),
    .lbc_data (lbc_data), .lbc_data_oe (lbc_data_oe)
  );

  lbc_bus_target i_target (
    .busclk (busclk), .arst_n (arst_n), .lbc_req (lbc_req),
    .lbc_frame (lbc_frame), .lbc_irdy (lbc_irdy), .lbc_addr (lbc_addr),
    .lbc_be (lbc_be), .lbc_data (lbc_data), .lbc_data_oe (lbc_data_oe),
    .wait_n (wait_n), .abort_once (abort_once), .stall (stall),
    .lbus_gnt (lbus_gnt), .lbus_trdy (lbus_trdy), .lbus_abort (lbus_abort),
    .lbus_data (lbus_data), .last_be (last_be)
  );

  // budget per transfer in busclk periods, plus the reset span
  initial begin
    #(XFER_COUNT * (4 * SYNC_STAGES + MAX_WAIT + 10) * 130 + 20 * 100);
    $display("timeout: the tests did not finish in the allowed time");
    $display("Verification failed");
    $finish;
  end

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [3:0] exp_be(input logic [31:0] addr, input lbc_size_e size);
    logic [3:0] base;
    base = (size == SIZE_BYTE) ? 4'b0001 : (size == SIZE_HALF) ? 4'b0011 : 4'b1111;
    return base << addr[1:0];
  endfunction

  function automatic logic [31:0] exp_read(input logic [31:0] addr, input lbc_size_e size);
    logic [31:0] word;
    word = ref_mem[addr[7:2]] >> (8 * addr[1:0]);
    if (size == SIZE_BYTE) return word & 32'h0000_00ff;
    if (size == SIZE_HALF) return word & 32'h0000_ffff;
    return word;
  endfunction

  task automatic ref_write(input logic [31:0] addr, input lbc_size_e size,
                           input logic [31:0] wdata);
    logic [3:0] be;
    be = exp_be(addr, size);
    for (int k = 0; k < 4; k++) begin
      if (be[k]) ref_mem[addr[7:2]][8*k +: 8] = wdata[8*(k - addr[1:0]) +: 8];
    end
  endtask

  task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("** Error: %s expected %h actual %h", test, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_true(input string test, input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test, what);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string test, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: ok", test);
      tests_ok++;
    end else begin
      $display("%s: failed", test);
      tests_bad++;
    end
  endtask

  // one cpu request, waits for acceptance and for the read result
  task automatic cpu_access(input string test, input logic rw, input lbc_size_e size,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output bit rval, output bit berr,
                            output bit held, output bit align);
    int n;
    @(negedge sysclk);
    cpu_req   = 1'b1;
    cpu_rw    = rw;
    cpu_size  = size;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    #1;
    held = 0;
    n    = 0;
    while (cpu_halt && n < LIMIT) begin
      held = 1;
      @(negedge sysclk);
      #1;
      n++;
    end
    check_true(test, n < LIMIT, "request was never accepted");
    @(negedge sysclk);
    cpu_req = 1'b0;
    align   = cpu_align_err;
    rval    = 0;
    berr    = 0;
    rdata   = '0;
    if (!rw && !align) begin
      n = 0;
      while (!(cpu_rval || cpu_bus_err) && n < LIMIT) begin
        @(negedge sysclk);
        n++;
      end
      check_true(test, n < LIMIT, "no read result came back");
      rval  = cpu_rval;
      berr  = cpu_bus_err;
      rdata = cpu_rdata;
      check_true(test, !cpu_halt, "cpu_halt still high with the result");
    end
  endtask

  task automatic wait_idle(input string test);
    int n;
    n = 0;
    while (!cpu_wbempty && n < LIMIT) begin
      @(negedge sysclk);
      n++;
    end
    check_true(test, n < LIMIT, "write buffer never drained");
  endtask

  task automatic test_reset();
    int e;
    e = err_cnt;
    check_value("reset", 32'h0, 32'({cpu_halt, cpu_rval, cpu_align_err, cpu_bus_err}));
    check_value("reset", 32'h0, 32'({lbc_req, lbc_frame, lbc_irdy, lbc_data_oe}));
    check_value("reset", 32'h1, 32'(cpu_wbempty));
    finish_test("reset", e);
  endtask

  task automatic test_word();
    int e;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    bit rv, be, hd, al;
    e = err_cnt;
    for (int i = 0; i < 8; i++) begin
      addr = xorshift() & 32'h0000_00fc;
      data = xorshift();
      cpu_access("word", 1'b1, SIZE_WORD, addr, data, rd, rv, be, hd, al);
      ref_write(addr, SIZE_WORD, data);
      cpu_access("word", 1'b0, SIZE_WORD, addr, 32'h0, rd, rv, be, hd, al);
      check_true("word", rv && !be, "read did not end with cpu_rval");
      check_value("word", data, rd);
    end
    wait_idle("word");
    finish_test("word", e);
  endtask

  task automatic test_subword();
    int e;
    logic [31:0] base;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    bit rv, be, hd, al;
    e = err_cnt;
    base = xorshift() & 32'h0000_00fc;
    for (int lane = 0; lane < 4; lane++) begin
      addr = base + lane;
      data = xorshift();
      cpu_access("subword", 1'b1, SIZE_BYTE, addr, data, rd, rv, be, hd, al);
      ref_write(addr, SIZE_BYTE, data);
      wait_idle("subword");
      check_value("subword be", 32'(exp_be(addr, SIZE_BYTE)), 32'(last_be));
      check_value("subword cmd", 32'(CMD_WR_BYTE), 32'(last_cmd));
      cpu_access("subword", 1'b0, SIZE_BYTE, addr, 32'h0, rd, rv, be, hd, al);
      check_value("subword byte", exp_read(addr, SIZE_BYTE), rd);
      check_value("subword cmd", 32'(CMD_RD_BYTE), 32'(last_cmd));
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      addr = base + lane;
      data = xorshift();
      cpu_access("subword", 1'b1, SIZE_HALF, addr, data, rd, rv, be, hd, al);
      ref_write(addr, SIZE_HALF, data);
      wait_idle("subword");
      check_value("subword be", 32'(exp_be(addr, SIZE_HALF)), 32'(last_be));
      check_value("subword cmd", 32'(CMD_WR_HALF), 32'(last_cmd));
      cpu_access("subword", 1'b0, SIZE_HALF, addr, 32'h0, rd, rv, be, hd, al);
      check_value("subword half", exp_read(addr, SIZE_HALF), rd);
      check_value("subword cmd", 32'(CMD_RD_HALF), 32'(last_cmd));
    end
    finish_test("subword", e);
  endtask

  task automatic test_abort_wait();
    int e;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    bit rv, be, hd, al;
    e = err_cnt;
    addr = xorshift() & 32'h0000_00fc;
    data = xorshift();
    cpu_access("abort", 1'b1, SIZE_WORD, addr, data, rd, rv, be, hd, al);
    ref_write(addr, SIZE_WORD, data);
    wait_idle("abort");
    wait_n     = 8'd5;
    abort_once = 1'b1;
    cpu_access("abort", 1'b0, SIZE_WORD, addr, 32'h0, rd, rv, be, hd, al);
    check_true("abort", rv && !be, "read after abort did not complete cleanly");
    check_value("abort", data, rd);
    wait_idle("abort");
    abort_once = 1'b0;
    wait_n     = 8'd0;
    finish_test("abort", e);
  endtask

  task automatic test_timeout();
    int e;
    logic [31:0] rd;
    bit rv, be, hd, al;
    e = err_cnt;
    stall = 1'b1;
    cpu_access("timeout", 1'b0, SIZE_WORD, 32'h40, 32'h0, rd, rv, be, hd, al);
    check_true("timeout", be, "cpu_bus_err did not pulse");
    check_true("timeout", !rv, "cpu_rval pulsed on a timed out read");
    wait_idle("timeout");
    stall = 1'b0;
    finish_test("timeout", e);
  endtask

  task automatic test_backpressure();
    int e;
    int reqs;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] rd;
    bit rv, be, hd, al;
    e  = err_cnt;
    a0 = 32'h80;
    a1 = 32'h84;
    d0 = xorshift();
    d1 = xorshift();
    wait_n = 8'd3;
    cpu_access("backpressure", 1'b1, SIZE_WORD, a0, d0, rd, rv, be, hd, al);
    cpu_access("backpressure", 1'b1, SIZE_WORD, a1, d1, rd, rv, be, hd, al);
    check_true("backpressure", hd, "second write was not held by cpu_halt");
    ref_write(a0, SIZE_WORD, d0);
    ref_write(a1, SIZE_WORD, d1);
    wait_idle("backpressure");
    wait_n = 8'd0;
    cpu_access("backpressure", 1'b0, SIZE_WORD, a0, 32'h0, rd, rv, be, hd, al);
    check_value("backpressure", d0, rd);
    cpu_access("backpressure", 1'b0, SIZE_WORD, a1, 32'h0, rd, rv, be, hd, al);
    check_value("backpressure", d1, rd);
    reqs = req_count;
    cpu_access("align", 1'b0, SIZE_HALF, 32'h91, 32'h0, rd, rv, be, hd, al);
    check_true("align", al && !hd, "misaligned half-word not rejected");
    cpu_access("align", 1'b1, SIZE_WORD, 32'h92, 32'h0, rd, rv, be, hd, al);
    check_true("align", al && !hd, "misaligned word not rejected");
    repeat (20) @(negedge sysclk);
    check_value("align", reqs, req_count);
    finish_test("backpressure", e);
  endtask

  initial begin
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000;
    end
    arst_n     = 1'b0;
    cpu_req    = 1'b0;
    cpu_rw     = 1'b0;
    cpu_size   = SIZE_WORD;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    wait_n     = 8'd0;
    abort_once = 1'b0;
    stall      = 1'b0;
    repeat (8) @(posedge sysclk);
    @(negedge sysclk);
    arst_n = 1'b1;
    repeat (2) @(negedge sysclk);
    test_reset();
    test_word();
    test_subword();
    test_abort_wait();
    test_timeout();
    test_backpressure();
    $display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: files.f
logic/lbc_cmd_pkg.sv
logic/lbc_bus_pkg.sv
logic/lbc_async.sv
logic/lbc_cbus_decode.sv
logic/lbc_lbus_exec.sv
logic/lbc_result.sv
logic/lbc_lbi.sv
bench/lbc_bus_target.sv
bench/lbc_lbi_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module lbc_lbi_tb -o lbc_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/lbc_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
exit 1
